/* flist.f */
+incdir+.
csr_pkg.sv
csr_wr_if.sv
csr_ctrl.sv
csr_mode_regs.sv
csr_int_regs.sv
csr_timer.sv
csr_save_regs.sv
csr_read_mux.sv
csr_top.sv
tb_csr_top.sv

/* tb_csr_tests.svh */
task automatic masked_writes();
    csr_word_t mask;
    csr_word_t val;
    csr_word_t got;
    csr_word_t exp_v;
    csr_num_t  num;
    csr_word_t model [NUM_SAVE+1];
    // save words and tid all start at zero
    for (int i = 0; i <= NUM_SAVE; i++)
        model[i] = '0;
    // second round merges into non-reset contents
    for (int round = 0; round < 2; round++) begin
        for (int i = 0; i <= NUM_SAVE; i++) begin
            num = (i == NUM_SAVE) ? csr_num_t'(CSR_TID) : csr_num_t'(CSR_SAVE0 + i);
            mask = lcg_next();
            val  = lcg_next();
            for (int b = 0; b < 32; b++)
                exp_v[b] = mask[b] ? val[b] : model[i][b];
            model[i] = exp_v;
            write_csr(num, mask, val);
            read_csr(num, got);
            check_word($sformatf("masked write to csr 0x%0h", num), got, exp_v);
        end
    end
    val = lcg_next();
    write_csr(CSR_EENTRY, '1, val);
    read_csr(CSR_EENTRY, got);
    check_word("eentry low bits", got, {val[31:6], 6'b0});
    // bits 10 and 12 are never writable
    write_csr(CSR_ECFG, '1, '1);
    read_csr(CSR_ECFG, got);
    check_word("ecfg writable bits", got, 32'h0000_0bff);
endtask

task automatic exception_entry();
    csr_word_t pc;
    csr_word_t got;
    csr_word_t entry;
    entry = lcg_next();
    write_csr(CSR_EENTRY, '1, entry);
    pc = lcg_next();
    write_csr(CSR_CRMD, 32'h7, 32'h7);
    pulse_exception(ECODE_SYS, '0, pc, '0);
    read_csr(CSR_CRMD, got);
    check_word("crmd plv and ie after exception", got & 32'h7, 32'h0);
    read_csr(CSR_PRMD, got);
    check_word("prmd after exception", got & 32'h7, 32'h7);
    read_csr(CSR_ERA, got);
    check_word("era after exception", got, pc);
    read_csr(CSR_ESTAT, got);
    check_word("estat ecode", (got >> ESTAT_ECODE_LSB) & 32'h3f, 32'h0b);
    check_word("estat esubcode", (got >> ESTAT_ESUB_LSB) & 32'h1ff, 32'h0);
    check_word("ex_entry", ex_entry, {entry[31:6], 6'b0});
endtask

task automatic bad_address_capture();
    csr_word_t pc;
    csr_word_t va;
    csr_word_t got;
    csr_word_t prev;
    pc = lcg_next();
    va = lcg_next();
    pulse_exception(ECODE_ALE, '0, pc, va);
    read_csr(CSR_BADV, got);
    check_word("badv after ale", got, va);
    pc = lcg_next();
    va = lcg_next();
    pulse_exception(ECODE_ADE, ESUBCODE_ADEF, pc, va);
    read_csr(CSR_BADV, got);
    check_word("badv after fetch ade", got, pc);
    prev = got;
    pc = lcg_next();
    va = lcg_next();
    pulse_exception(ECODE_BRK, '0, pc, va);
    read_csr(CSR_BADV, got);
    check_word("badv after brk", got, prev);
endtask

task automatic exception_return();
    csr_word_t era_v;
    csr_word_t old_v;
    csr_word_t got;
    era_v = lcg_next();
    write_csr(CSR_ERA, '1, era_v);
    @(negedge clk);
    check_word("ertn_entry follows era", ertn_entry, era_v);
    // plv 2 with ie on
    write_csr(CSR_PRMD, 32'h7, 32'h6);
    pulse_ertn();
    read_csr(CSR_CRMD, got);
    check_word("crmd after ertn", got & 32'h7, 32'h6);
    read_csr(CSR_SAVE0, old_v);
    @(posedge clk);
    csr_num    <= CSR_SAVE0;
    csr_we     <= 1'b1;
    csr_wmask  <= '1;
    csr_wvalue <= ~old_v;
    wb_ex      <= 1'b1;
    wb_ecode   <= ECODE_SYS;
    wb_pc      <= era_v;
    @(posedge clk);
    csr_we <= 1'b0;
    wb_ex  <= 1'b0;
    read_csr(CSR_SAVE0, got);
    check_word("save0 write during exception", got, old_v);
endtask

task automatic software_interrupt();
    csr_word_t got;
    write_csr(CSR_ECFG, '1, 32'h3);
    write_csr(CSR_CRMD, 32'h4, 32'h0);
    write_csr(CSR_ESTAT, 32'h3, 32'h3);
    read_csr(CSR_ESTAT, got);
    check_word("estat software bits", got & 32'h3, 32'h3);
    expect_has_int(1'b0, "has_int with ie off");
    write_csr(CSR_CRMD, 32'h4, 32'h4);
    expect_has_int(1'b1, "has_int with ie on");
    write_csr(CSR_ECFG, '1, 32'h1);
    write_csr(CSR_ESTAT, 32'h3, 32'h2);
    expect_has_int(1'b0, "has_int with bit 1 not enabled");
    write_csr(CSR_ESTAT, 32'h3, 32'h1);
    expect_has_int(1'b1, "has_int with bit 0 enabled");
    write_csr(CSR_ESTAT, 32'h3, 32'h0);
    expect_has_int(1'b0, "has_int after clearing software bits");
endtask

task automatic timer_interrupt();
    csr_word_t t1;
    csr_word_t t2;
    csr_word_t got;
    write_csr(CSR_ECFG, '1, 32'h800);
    // one-shot, initial value 5
    write_csr(CSR_TCFG, '1, (32'd5 << TCFG_INITVAL_LSB) | 32'h1);
    read_csr(CSR_TVAL, t1);
    check_bit("tval within initial count", t1 <= 32'd20, 1'b1);
    read_csr(CSR_TVAL, t2);
    check_bit("tval counts down", t2 < t1, 1'b1);
    wait_timer_bit(1'b1, 40);
    expect_has_int(1'b1, "has_int from timer");
    write_csr(CSR_TICLR, 32'h1, 32'h1);
    read_csr(CSR_ESTAT, got);
    check_bit("timer bit cleared", got[TIMER_INT_BIT], 1'b0);
    read_csr(CSR_TVAL, got);
    check_word("one-shot tval ends at all ones", got, '1);
    read_csr(CSR_ESTAT, got);
    check_bit("timer bit stays clear", got[TIMER_INT_BIT], 1'b0);
    expect_has_int(1'b0, "has_int after timer clear");
    // periodic, initial value 3
    write_csr(CSR_TCFG, '1, (32'd3 << TCFG_INITVAL_LSB) | 32'h3);
    wait_timer_bit(1'b1, 40);
    write_csr(CSR_TICLR, 32'h1, 32'h1);
    wait_timer_bit(1'b0, 10);
    wait_timer_bit(1'b1, 40);
    write_csr(CSR_TCFG, '1, '0);
endtask

/* tb_csr_top.sv */
`timescale 1ns/1ps

module tb_csr_top import csr_pkg::*; ();
    localparam int NUM_SAVE = 4;
    localparam int TIMER_W  = 32;

    logic        clk;
    logic        reset;
    csr_num_t    csr_num;
    csr_word_t   csr_rvalue;
    logic        csr_we;
    csr_word_t   csr_wmask;
    csr_word_t   csr_wvalue;
    csr_word_t   ex_entry;
    csr_word_t   ertn_entry;
    logic        has_int;
    logic        ertn_flush;
    logic        wb_ex;
    ecode_e      wb_ecode;
    esubcode_t   wb_esubcode;
    csr_word_t   wb_vaddr;
    csr_word_t   wb_pc;
    logic [31:0] lcg_state;

    csr_top #(.NUM_SAVE(NUM_SAVE), .TIMER_W(TIMER_W)) u_csr_top (
        .clk(clk), .reset(reset), .csr_num(csr_num), .csr_rvalue(csr_rvalue),
        .csr_we(csr_we), .csr_wmask(csr_wmask), .csr_wvalue(csr_wvalue),
        .ex_entry(ex_entry), .ertn_entry(ertn_entry), .has_int(has_int),
        .ertn_flush(ertn_flush), .wb_ex(wb_ex), .wb_ecode(wb_ecode),
        .wb_esubcode(wb_esubcode), .wb_vaddr(wb_vaddr), .wb_pc(wb_pc)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function csr_word_t lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    task automatic abort_run();
        $display("Finished with errors");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_word(input string what, input csr_word_t got, input csr_word_t exp);
        if (got !== exp) begin
            $display("FAILED at %0t ns: %s, got %h, expected %h", $time, what, got, exp);
            abort_run();
        end
    endtask

    task automatic check_bit(input string what, input logic got, input logic exp);
        if (got !== exp) begin
            $display("FAILED at %0t ns: %s, got %b, expected %b", $time, what, got, exp);
            abort_run();
        end
    endtask

    // write is sampled by the DUT at the second edge
    task automatic write_csr(input csr_num_t num, input csr_word_t mask, input csr_word_t val);
        @(posedge clk);
        csr_num    <= num;
        csr_we     <= 1'b1;
        csr_wmask  <= mask;
        csr_wvalue <= val;
        @(posedge clk);
        csr_we <= 1'b0;
    endtask

    task automatic read_csr(input csr_num_t num, output csr_word_t val);
        @(posedge clk);
        csr_num <= num;
        @(negedge clk);
        val = csr_rvalue;
    endtask

    task automatic pulse_exception(input ecode_e code, input esubcode_t sub,
                                   input csr_word_t pc, input csr_word_t vaddr);
        @(posedge clk);
        wb_ex       <= 1'b1;
        wb_ecode    <= code;
        wb_esubcode <= sub;
        wb_pc       <= pc;
        wb_vaddr    <= vaddr;
        @(posedge clk);
        wb_ex <= 1'b0;
    endtask

    task automatic pulse_ertn();
        @(posedge clk);
        ertn_flush <= 1'b1;
        @(posedge clk);
        ertn_flush <= 1'b0;
    endtask

    task automatic expect_has_int(input logic exp, input string what);
        @(negedge clk);
        check_bit(what, has_int, exp);
    endtask

    // polls estat bit 11 once per cycle
    task automatic wait_timer_bit(input logic level, input int max_cycles);
        csr_word_t v;
        int        n;
        n = 0;
        read_csr(CSR_ESTAT, v);
        while (v[TIMER_INT_BIT] !== level) begin
            n++;
            if (n > max_cycles) begin
                $display("timeout: timer interrupt bit did not become %0b", level);
                abort_run();
            end
            read_csr(CSR_ESTAT, v);
        end
    endtask

    `include "tb_csr_tests.svh"

    initial begin
        lcg_state   = 32'd83949;
        reset       = 1'b1;
        csr_num     = '0;
        csr_we      = 1'b0;
        csr_wmask   = '0;
        csr_wvalue  = '0;
        ertn_flush  = 1'b0;
        wb_ex       = 1'b0;
        wb_ecode    = ECODE_INT;
        wb_esubcode = '0;
        wb_vaddr    = '0;
        wb_pc       = '0;
        repeat (16) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        check_bit("has_int after reset", has_int, 1'b0);
        check_word("ex_entry after reset", ex_entry, '0);
        check_word("ertn_entry after reset", ertn_entry, '0);
        masked_writes();
        exception_entry();
        bad_address_capture();
        exception_return();
        software_interrupt();
        timer_interrupt();
        $display("Finished with no errors");
        $finish;
    end

endmodule

/* csr_top.sv */
`timescale 1ns/1ps

module csr_top import csr_pkg::*; #(
    parameter int NUM_SAVE = 4,
    parameter int TIMER_W  = 32
) (
    input  logic      clk,
    input  logic      reset,
    input  csr_num_t  csr_num,
    output csr_word_t csr_rvalue,
    input  logic      csr_we,
    input  csr_word_t csr_wmask,
    input  csr_word_t csr_wvalue,
    output csr_word_t ex_entry,
    output csr_word_t ertn_entry,
    output logic      has_int,
    input  logic      ertn_flush,
    input  logic      wb_ex,
    input  ecode_e    wb_ecode,
    input  esubcode_t wb_esubcode,
    input  csr_word_t wb_vaddr,
    input  csr_word_t wb_pc
);
    logic      crmd_ie;
    logic      timer_zero;
    logic      ticlr_clear;
    csr_word_t crmd_word;
    csr_word_t prmd_word;
    csr_word_t estat_cause_word;
    csr_word_t badv_word;
    csr_word_t ecfg_word;
    csr_word_t estat_is_word;
    csr_word_t tid_word;
    csr_word_t tcfg_word;
    csr_word_t tval_word;
    csr_word_t save_words [NUM_SAVE];

    csr_wr_if #(.NUM_SAVE(NUM_SAVE)) wr_bus ();
    exc_if exc_bus ();

    csr_ctrl #(.NUM_SAVE(NUM_SAVE)) u_ctrl (
        .csr_num(csr_num), .csr_we(csr_we), .csr_wmask(csr_wmask),
        .csr_wvalue(csr_wvalue), .wb_ex(wb_ex), .ertn_flush(ertn_flush),
        .wb_ecode(wb_ecode), .wb_esubcode(wb_esubcode), .wb_pc(wb_pc),
        .wb_vaddr(wb_vaddr), .ticlr_clear(ticlr_clear), .wr(wr_bus), .exc(exc_bus)
    );

    // entry addresses come straight from eentry and era
    csr_mode_regs u_mode_regs (
        .clk(clk), .reset(reset), .wr(wr_bus), .exc(exc_bus), .crmd_ie(crmd_ie),
        .crmd_word(crmd_word), .prmd_word(prmd_word), .era_word(ertn_entry),
        .eentry_word(ex_entry), .estat_cause_word(estat_cause_word), .badv_word(badv_word)
    );

    csr_int_regs u_int_regs (
        .clk(clk), .reset(reset), .wr(wr_bus), .crmd_ie(crmd_ie),
        .timer_zero(timer_zero), .ticlr_clear(ticlr_clear), .ecfg_word(ecfg_word),
        .estat_is_word(estat_is_word), .has_int(has_int)
    );

    csr_timer #(.TIMER_W(TIMER_W)) u_timer (
        .clk(clk), .reset(reset), .wr(wr_bus), .timer_zero(timer_zero),
        .tid_word(tid_word), .tcfg_word(tcfg_word), .tval_word(tval_word)
    );

    csr_save_regs #(.NUM_SAVE(NUM_SAVE)) u_save_regs (
        .clk(clk), .reset(reset), .wr(wr_bus), .save_words(save_words)
    );

    csr_read_mux #(.NUM_SAVE(NUM_SAVE)) u_read_mux (
        .csr_num(csr_num), .crmd_word(crmd_word), .prmd_word(prmd_word),
        .ecfg_word(ecfg_word), .estat_cause_word(estat_cause_word),
        .estat_is_word(estat_is_word), .era_word(ertn_entry), .badv_word(badv_word),
        .eentry_word(ex_entry), .save_words(save_words), .tid_word(tid_word),
        .tcfg_word(tcfg_word), .tval_word(tval_word), .csr_rvalue(csr_rvalue)
    );

endmodule

/* csr_read_mux.sv */
`timescale 1ns/1ps

module csr_read_mux import csr_pkg::*; #(
    parameter int NUM_SAVE = 4
) (
    input  csr_num_t  csr_num,
    input  csr_word_t crmd_word,
    input  csr_word_t prmd_word,
    input  csr_word_t ecfg_word,
    input  csr_word_t estat_cause_word,
    input  csr_word_t estat_is_word,
    input  csr_word_t era_word,
    input  csr_word_t badv_word,
    input  csr_word_t eentry_word,
    input  csr_word_t save_words [NUM_SAVE],
    input  csr_word_t tid_word,
    input  csr_word_t tcfg_word,
    input  csr_word_t tval_word,
    output csr_word_t csr_rvalue
);

    // ticlr and unknown numbers fall through to zero
    always_comb begin
        csr_rvalue = '0;
        case (csr_num)
            CSR_CRMD:   csr_rvalue = crmd_word;
            CSR_PRMD:   csr_rvalue = prmd_word;
            CSR_ECFG:   csr_rvalue = ecfg_word;
            CSR_ESTAT:  csr_rvalue = estat_cause_word | estat_is_word;
            CSR_ERA:    csr_rvalue = era_word;
            CSR_BADV:   csr_rvalue = badv_word;
            CSR_EENTRY: csr_rvalue = eentry_word;
            CSR_TID:    csr_rvalue = tid_word;
            CSR_TCFG:   csr_rvalue = tcfg_word;
            CSR_TVAL:   csr_rvalue = tval_word;
            default: ;
        endcase
        for (int i = 0; i < NUM_SAVE; i++) begin
            if (csr_num == csr_num_t'(CSR_SAVE0 + i))
                csr_rvalue = save_words[i];
        end
    end

endmodule

/* csr_save_regs.sv */
`timescale 1ns/1ps

module csr_save_regs import csr_pkg::*; #(
    parameter int NUM_SAVE = 4
) (
    input  logic      clk,
    input  logic      reset,
    csr_wr_if.regs    wr,
    output csr_word_t save_words [NUM_SAVE]
);

    for (genvar i = 0; i < NUM_SAVE; i++) begin : g_save
        always_ff @(posedge clk) begin
            if (reset)
                save_words[i] <= '0;
            else if (wr.wr_save[i])
                save_words[i] <= mask_merge(save_words[i], wr.wmask, wr.wvalue);
        end
    end

endmodule

/* csr_timer.sv */
`timescale 1ns/1ps

module csr_timer import csr_pkg::*; #(
    parameter int TIMER_W = 32
) (
    input  logic      clk,
    input  logic      reset,
    csr_wr_if.regs    wr,
    output logic      timer_zero,
    output csr_word_t tid_word,
    output csr_word_t tcfg_word,
    output csr_word_t tval_word
);
    logic                        tcfg_en;
    logic                        tcfg_periodic;
    logic [31:TCFG_INITVAL_LSB]  tcfg_initval;
    logic [TIMER_W-1:0]          count;
    csr_word_t                   tcfg_next;

    // initval sits above the two low bits, so this is initval * 4
    function automatic logic [TIMER_W-1:0] start_count(csr_word_t cfg);
        return TIMER_W'({cfg[31:TCFG_INITVAL_LSB], {TCFG_INITVAL_LSB{1'b0}}});
    endfunction

    assign tcfg_next = mask_merge(tcfg_word, wr.wmask, wr.wvalue);

    always_ff @(posedge clk) begin
        if (reset) begin
            tid_word      <= '0;
            tcfg_en       <= 1'b0;
            tcfg_periodic <= 1'b0;
            tcfg_initval  <= '0;
        end else begin
            if (wr.wr_tid)
                tid_word <= mask_merge(tid_word, wr.wmask, wr.wvalue);
            if (wr.wr_tcfg) begin
                tcfg_en       <= tcfg_next[TCFG_EN_BIT];
                tcfg_periodic <= tcfg_next[TCFG_PERIODIC_BIT];
                tcfg_initval  <= tcfg_next[31:TCFG_INITVAL_LSB];
            end
        end
    end

    // one-shot mode runs past zero to all ones and parks there
    always_ff @(posedge clk) begin
        if (reset)
            count <= '1;
        else if (wr.wr_tcfg && tcfg_next[TCFG_EN_BIT])
            count <= start_count(tcfg_next);
        else if (tcfg_en && count != '1) begin
            if (count == '0 && tcfg_periodic)
                count <= start_count(tcfg_word);
            else
                count <= count - 1'b1;
        end
    end

    always_comb begin
        tcfg_word = '0;
        tcfg_word[TCFG_EN_BIT]            = tcfg_en;
        tcfg_word[TCFG_PERIODIC_BIT]      = tcfg_periodic;
        tcfg_word[31:TCFG_INITVAL_LSB]    = tcfg_initval;
    end

    assign tval_word  = csr_word_t'(count);
    assign timer_zero = tcfg_en & (count == '0);

endmodule

/* csr_int_regs.sv */
`timescale 1ns/1ps

module csr_int_regs import csr_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    csr_wr_if.regs    wr,
    input  logic      crmd_ie,
    input  logic      timer_zero,
    input  logic      ticlr_clear,
    output csr_word_t ecfg_word,
    output csr_word_t estat_is_word,
    output logic      has_int
);
    logic [IS_W-1:0] ecfg_lie;
    logic [1:0]      swi;
    logic            timer_int;
    logic [IS_W-1:0] is_vec;
    csr_word_t       ecfg_next;
    csr_word_t       estat_next;

    assign ecfg_next  = mask_merge(ecfg_word, wr.wmask, wr.wvalue);
    assign estat_next = mask_merge(estat_is_word, wr.wmask, wr.wvalue);

    always_ff @(posedge clk) begin
        if (reset) begin
            ecfg_lie  <= '0;
            swi       <= '0;
            timer_int <= 1'b0;
        end else begin
            if (wr.wr_ecfg)
                ecfg_lie <= ecfg_next[IS_W-1:0] & LIE_WRITABLE;
            if (wr.wr_estat)
                swi <= estat_next[1:0];
            // a zero count wins over a clear in the same cycle
            if (timer_zero)
                timer_int <= 1'b1;
            else if (ticlr_clear)
                timer_int <= 1'b0;
        end
    end

    // hw and ipi lines are not present, read as zero
    always_comb begin
        is_vec = '0;
        is_vec[1:0] = swi;
        is_vec[TIMER_INT_BIT] = timer_int;
    end

    assign ecfg_word     = csr_word_t'(ecfg_lie);
    assign estat_is_word = csr_word_t'(is_vec);
    assign has_int = (|(is_vec[TIMER_INT_BIT:0] & ecfg_lie[TIMER_INT_BIT:0])) & crmd_ie;

endmodule

/* csr_mode_regs.sv */
`timescale 1ns/1ps

module csr_mode_regs import csr_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    csr_wr_if.regs    wr,
    exc_if.regs       exc,
    output logic      crmd_ie,
    output csr_word_t crmd_word,
    output csr_word_t prmd_word,
    output csr_word_t era_word,
    output csr_word_t eentry_word,
    output csr_word_t estat_cause_word,
    output csr_word_t badv_word
);
    plv_t                   crmd_plv;
    logic                   crmd_da;
    logic                   crmd_pg;
    logic [1:0]             crmd_datf;
    logic [1:0]             crmd_datm;
    plv_t                   prmd_pplv;
    logic                   prmd_pie;
    logic [31:ENTRY_ALIGN_W] eentry_va;
    ecode_e                 estat_ecode;
    esubcode_t              estat_esub;
    csr_word_t              crmd_next;
    csr_word_t              prmd_next;
    csr_word_t              eentry_next;

    assign crmd_next   = mask_merge(crmd_word, wr.wmask, wr.wvalue);
    assign prmd_next   = mask_merge(prmd_word, wr.wmask, wr.wvalue);
    assign eentry_next = mask_merge(eentry_word, wr.wmask, wr.wvalue);

    always_ff @(posedge clk) begin
        if (reset) begin
            crmd_plv  <= '0;
            crmd_ie   <= 1'b0;
            crmd_da   <= 1'b1;
            crmd_pg   <= 1'b0;
            crmd_datf <= '0;
            crmd_datm <= '0;
        end else if (exc.ex_take) begin
            // enter the handler at plv0 with interrupts off
            crmd_plv <= '0;
            crmd_ie  <= 1'b0;
        end else if (exc.ertn_take) begin
            crmd_plv <= prmd_pplv;
            crmd_ie  <= prmd_pie;
        end else if (wr.wr_crmd) begin
            crmd_plv  <= crmd_next[CRMD_PLV_LSB +: 2];
            crmd_ie   <= crmd_next[CRMD_IE_BIT];
            crmd_da   <= crmd_next[CRMD_DA_BIT];
            crmd_pg   <= crmd_next[CRMD_PG_BIT];
            crmd_datf <= crmd_next[CRMD_DATF_LSB +: 2];
            crmd_datm <= crmd_next[CRMD_DATM_LSB +: 2];
        end
    end

    // prmd shares the plv/ie bit layout of crmd
    always_ff @(posedge clk) begin
        if (reset) begin
            prmd_pplv <= '0;
            prmd_pie  <= 1'b0;
        end else if (exc.ex_take) begin
            prmd_pplv <= crmd_plv;
            prmd_pie  <= crmd_ie;
        end else if (wr.wr_prmd) begin
            prmd_pplv <= prmd_next[CRMD_PLV_LSB +: 2];
            prmd_pie  <= prmd_next[CRMD_IE_BIT];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            era_word    <= '0;
            eentry_va   <= '0;
            estat_ecode <= ECODE_INT;
            estat_esub  <= '0;
            badv_word   <= '0;
        end else begin
            if (exc.ex_take) begin
                era_word    <= exc.ex_pc;
                estat_ecode <= exc.ex_ecode;
                estat_esub  <= exc.ex_esubcode;
            end else if (wr.wr_era) begin
                era_word <= mask_merge(era_word, wr.wmask, wr.wvalue);
            end
            if (wr.wr_eentry)
                eentry_va <= eentry_next[31:ENTRY_ALIGN_W];
            if (exc.badv_we)
                badv_word <= exc.badv_value;
        end
    end

    always_comb begin
        crmd_word = '0;
        crmd_word[CRMD_PLV_LSB +: 2]  = crmd_plv;
        crmd_word[CRMD_IE_BIT]        = crmd_ie;
        crmd_word[CRMD_DA_BIT]        = crmd_da;
        crmd_word[CRMD_PG_BIT]        = crmd_pg;
        crmd_word[CRMD_DATF_LSB +: 2] = crmd_datf;
        crmd_word[CRMD_DATM_LSB +: 2] = crmd_datm;
        prmd_word = '0;
        prmd_word[CRMD_PLV_LSB +: 2]  = prmd_pplv;
        prmd_word[CRMD_IE_BIT]        = prmd_pie;
        estat_cause_word = '0;
        estat_cause_word[ESTAT_ECODE_LSB +: $bits(ecode_e)]   = estat_ecode;
        estat_cause_word[ESTAT_ESUB_LSB +: $bits(esubcode_t)] = estat_esub;
    end

    assign eentry_word = {eentry_va, {ENTRY_ALIGN_W{1'b0}}};

endmodule

/* csr_ctrl.sv */
`timescale 1ns/1ps

module csr_ctrl import csr_pkg::*; #(
    parameter int NUM_SAVE = 4
) (
    input  csr_num_t  csr_num,
    input  logic      csr_we,
    input  csr_word_t csr_wmask,
    input  csr_word_t csr_wvalue,
    input  logic      wb_ex,
    input  logic      ertn_flush,
    input  ecode_e    wb_ecode,
    input  esubcode_t wb_esubcode,
    input  csr_word_t wb_pc,
    input  csr_word_t wb_vaddr,
    output logic      ticlr_clear,
    csr_wr_if.ctrl    wr,
    exc_if.ctrl       exc
);
    logic sw_we;
    logic addr_err;
    logic fetch_err;

    // write-back events win over a software write
    assign sw_we = csr_we & ~wb_ex & ~ertn_flush;

    always_comb begin
        wr.wr_crmd   = 1'b0;
        wr.wr_prmd   = 1'b0;
        wr.wr_ecfg   = 1'b0;
        wr.wr_estat  = 1'b0;
        wr.wr_era    = 1'b0;
        wr.wr_eentry = 1'b0;
        wr.wr_save   = '0;
        wr.wr_tid    = 1'b0;
        wr.wr_tcfg   = 1'b0;
        wr.wr_ticlr  = 1'b0;
        if (sw_we) begin
            case (csr_num)
                CSR_CRMD:   wr.wr_crmd   = 1'b1;
                CSR_PRMD:   wr.wr_prmd   = 1'b1;
                CSR_ECFG:   wr.wr_ecfg   = 1'b1;
                CSR_ESTAT:  wr.wr_estat  = 1'b1;
                CSR_ERA:    wr.wr_era    = 1'b1;
                CSR_EENTRY: wr.wr_eentry = 1'b1;
                CSR_TID:    wr.wr_tid    = 1'b1;
                CSR_TCFG:   wr.wr_tcfg   = 1'b1;
                CSR_TICLR:  wr.wr_ticlr  = 1'b1;
                default: ;
            endcase
            for (int i = 0; i < NUM_SAVE; i++) begin
                if (csr_num == csr_num_t'(CSR_SAVE0 + i))
                    wr.wr_save[i] = 1'b1;
            end
        end
    end

    assign wr.wmask  = csr_wmask;
    assign wr.wvalue = csr_wvalue;

    assign ticlr_clear = wr.wr_ticlr & csr_wmask[TICLR_CLR_BIT] & csr_wvalue[TICLR_CLR_BIT];

    assign exc.ex_take     = wb_ex;
    assign exc.ertn_take   = ertn_flush & ~wb_ex;
    assign exc.ex_ecode    = wb_ecode;
    assign exc.ex_esubcode = wb_esubcode;
    assign exc.ex_pc       = wb_pc;

    // fetch address errors report the pc, data errors the access address
    assign addr_err       = (wb_ecode == ECODE_ALE) || (wb_ecode == ECODE_ADE);
    assign fetch_err      = (wb_ecode == ECODE_ADE) && (wb_esubcode == ESUBCODE_ADEF);
    assign exc.badv_we    = wb_ex & addr_err;
    assign exc.badv_value = fetch_err ? wb_pc : wb_vaddr;

endmodule

/* csr_wr_if.sv */
`timescale 1ns/1ps

interface csr_wr_if import csr_pkg::*; #(parameter int NUM_SAVE = 4) ();
    logic                wr_crmd;
    logic                wr_prmd;
    logic                wr_ecfg;
    logic                wr_estat;
    logic                wr_era;
    logic                wr_eentry;
    logic [NUM_SAVE-1:0] wr_save;
    logic                wr_tid;
    logic                wr_tcfg;
    logic                wr_ticlr;
    csr_word_t           wmask;
    csr_word_t           wvalue;

    modport ctrl (
        output wr_crmd, wr_prmd, wr_ecfg, wr_estat, wr_era, wr_eentry,
        output wr_save, wr_tid, wr_tcfg, wr_ticlr, wmask, wvalue
    );
    modport regs (
        input wr_crmd, wr_prmd, wr_ecfg, wr_estat, wr_era, wr_eentry,
        input wr_save, wr_tid, wr_tcfg, wr_ticlr, wmask, wvalue
    );
endinterface

interface exc_if import csr_pkg::*; ();
    logic      ex_take;
    logic      ertn_take;
    ecode_e    ex_ecode;
    esubcode_t ex_esubcode;
    csr_word_t ex_pc;
    logic      badv_we;
    csr_word_t badv_value;

    modport ctrl (
        output ex_take, ertn_take, ex_ecode, ex_esubcode, ex_pc, badv_we, badv_value
    );
    modport regs (
        input ex_take, ertn_take, ex_ecode, ex_esubcode, ex_pc, badv_we, badv_value
    );
endinterface

/* csr_pkg.sv */
package csr_pkg;

    typedef logic [31:0] csr_word_t;
    typedef logic [13:0] csr_num_t;
    typedef logic [8:0]  esubcode_t;
    typedef logic [1:0]  plv_t;

    typedef enum csr_num_t {
        CSR_CRMD   = 14'h00,
        CSR_PRMD   = 14'h01,
        CSR_ECFG   = 14'h04,
        CSR_ESTAT  = 14'h05,
        CSR_ERA    = 14'h06,
        CSR_BADV   = 14'h07,
        CSR_EENTRY = 14'h0c,
        // scratch words follow consecutively
        CSR_SAVE0  = 14'h30,
        CSR_TID    = 14'h40,
        CSR_TCFG   = 14'h41,
        CSR_TVAL   = 14'h42,
        CSR_TICLR  = 14'h44
    } csr_addr_e;

    typedef enum logic [5:0] {
        ECODE_INT = 6'h00,
        ECODE_ADE = 6'h08,
        ECODE_ALE = 6'h09,
        ECODE_SYS = 6'h0b,
        ECODE_BRK = 6'h0c,
        ECODE_INE = 6'h0d
    } ecode_e;

    localparam esubcode_t ESUBCODE_ADEF = '0;

    localparam int CRMD_PLV_LSB      = 0;
    localparam int CRMD_IE_BIT       = 2;
    localparam int CRMD_DA_BIT       = 3;
    localparam int CRMD_PG_BIT       = 4;
    localparam int CRMD_DATF_LSB     = 5;
    localparam int CRMD_DATM_LSB     = 7;
    localparam int ESTAT_ECODE_LSB   = 16;
    localparam int ESTAT_ESUB_LSB    = 22;
    localparam int TCFG_EN_BIT       = 0;
    localparam int TCFG_PERIODIC_BIT = 1;
    localparam int TCFG_INITVAL_LSB  = 2;
    localparam int TICLR_CLR_BIT     = 0;
    localparam int TIMER_INT_BIT     = 11;

    localparam int ENTRY_ALIGN_W = 6;
    localparam int IS_W          = 13;

    // no software write to bits 10 and 12
    localparam logic [IS_W-1:0] LIE_WRITABLE = 13'h0bff;

    // new value where mask is one, old value elsewhere
    function automatic csr_word_t mask_merge(csr_word_t old_v, csr_word_t mask, csr_word_t val);
        return (mask & val) | (~mask & old_v);
    endfunction

endpackage
